// File: rot_mbox.f
verilog/rot_pkg.sv
verilog/mbox_rd_if.sv
verilog/boot_fsm.sv
verilog/mbox_ctrl.sv
verilog/mbox_digest.sv
verilog/rot_top.sv
tests/mbox_sram_model.sv
tests/rot_top_tb.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --top-module rot_top_tb -f rot_mbox.f \
    && ./obj_dir/Vrot_top_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Errors found" sim.log && exit 1
grep -q "No errors" sim.log || exit 1
exit 0

// File: tests/mbox_sram_model.sv
`timescale 1ns/1ps
`default_nettype none

// Mailbox SRAM outside the subsystem, one-cycle read latency
module mbox_sram_model
    import rot_pkg::*;
(
    input  logic       clk,
    input  logic       cs,
    input  logic       we,
    input  mbox_addr_t addr,
    input  word_t      wdata,
    output word_t      rdata
);

    word_t mem [MBOX_DEPTH];

    always @(posedge clk)
    begin
        if (cs && we)
        begin
            mem[addr] <= wdata;
        end
    end

    // Read data shows up the cycle after the request
    always @(posedge clk)
    begin
        if (cs && !we)
        begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: tests/rot_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rot_top_tb
    import rot_pkg::*;
();

    // Longest run is a few hundred cycles, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 5000;

    logic       core_clk;
    logic       rst;
    logic       fuse_we;
    fuse_addr_t fuse_addr;
    word_t      fuse_wdata;
    logic       fuse_done;
    logic       mbox_lock_req;
    logic       mbox_wr;
    word_t      mbox_wdata;
    logic       mbox_execute;
    logic       mbox_release;
    logic       ready_for_fuses;
    logic       ready_for_mb_processing;
    logic       mbox_lock;
    logic       mailbox_data_avail;
    word_t      mbox_resp;
    logic       cptra_error_non_fatal;
    logic       mbox_sram_cs;
    logic       mbox_sram_we;
    mbox_addr_t mbox_sram_addr;
    word_t      mbox_sram_wdata;
    word_t      mbox_sram_rdata;

    // Reference copies of the key and the current message
    word_t      key_ref [OBF_KEY_WORDS];
    word_t      msg [MBOX_DEPTH];
    word_t      lcg_state;
    int         cycles;

    rot_top uut (
        .clk                     (core_clk),
        .rst                     (rst),
        .fuse_we                 (fuse_we),
        .fuse_addr               (fuse_addr),
        .fuse_wdata              (fuse_wdata),
        .fuse_done               (fuse_done),
        .mbox_lock_req           (mbox_lock_req),
        .mbox_wr                 (mbox_wr),
        .mbox_wdata              (mbox_wdata),
        .mbox_execute            (mbox_execute),
        .mbox_release            (mbox_release),
        .ready_for_fuses         (ready_for_fuses),
        .ready_for_mb_processing (ready_for_mb_processing),
        .mbox_lock               (mbox_lock),
        .mailbox_data_avail      (mailbox_data_avail),
        .mbox_resp               (mbox_resp),
        .cptra_error_non_fatal   (cptra_error_non_fatal),
        .mbox_sram_cs            (mbox_sram_cs),
        .mbox_sram_we            (mbox_sram_we),
        .mbox_sram_addr          (mbox_sram_addr),
        .mbox_sram_wdata         (mbox_sram_wdata),
        .mbox_sram_rdata         (mbox_sram_rdata)
    );

    mbox_sram_model sram_i (
        .clk   (core_clk),
        .cs    (mbox_sram_cs),
        .we    (mbox_sram_we),
        .addr  (mbox_sram_addr),
        .wdata (mbox_sram_wdata),
        .rdata (mbox_sram_rdata)
    );

    initial
    begin
        core_clk = 1'b0;
        forever #20 core_clk = ~core_clk;
    end

    initial
    begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge core_clk);
            cycles = cycles + 1;
        end
        $display("Timeout: the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors found");
        $fatal(1, "simulation timed out");
    end

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Rotate left by one, then XOR in the word and key word i mod 4
    function automatic word_t expected_digest(input int n);
        word_t acc;
        acc = '0;
        for (int i = 0; i < n; i++)
        begin
            acc = {acc[30:0], acc[31]} ^ msg[i] ^ key_ref[i % OBF_KEY_WORDS];
        end
        return acc;
    endfunction

    task automatic check_val(input string test, input word_t expected, input word_t actual);
        if (expected !== actual)
        begin
            $display("FAIL %s expected %h actual %h", test, expected, actual);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge core_clk);
        #2;
    endtask

    task automatic expect_error_pulse(input string test);
        check_val(test, 32'd1, word_t'(cptra_error_non_fatal));
        next_cycle();
        check_val(test, 32'd0, word_t'(cptra_error_non_fatal));
    endtask

    task automatic lock_mbox(input string test);
        mbox_lock_req = 1'b1;
        next_cycle();
        mbox_lock_req = 1'b0;
        check_val(test, 32'd1, word_t'(mbox_lock));
    endtask

    task automatic release_mbox(input string test);
        mbox_release = 1'b1;
        next_cycle();
        mbox_release = 1'b0;
        check_val(test, 32'd0, word_t'(mbox_lock));
        check_val(test, 32'd0, word_t'(mailbox_data_avail));
    endtask

    // Write goes straight to the SRAM port in the same cycle
    task automatic write_word(input string test, input int idx, input word_t data);
        mbox_wr    = 1'b1;
        mbox_wdata = data;
        #10;
        check_val(test, 32'd1, word_t'(mbox_sram_cs));
        check_val(test, 32'd1, word_t'(mbox_sram_we));
        check_val(test, word_t'(idx), word_t'(mbox_sram_addr));
        check_val(test, data, mbox_sram_wdata);
        next_cycle();
        mbox_wr = 1'b0;
    endtask

    task automatic fill_message(input string test, input int n);
        for (int i = 0; i < n; i++)
        begin
            msg[i] = lcg_next();
            write_word(test, i, msg[i]);
        end
    endtask

    task automatic execute_and_wait(input string test, input int n);
        mbox_execute = 1'b1;
        next_cycle();
        mbox_execute = 1'b0;
        check_val(test, 32'd0, word_t'(cptra_error_non_fatal));
        while (mailbox_data_avail !== 1'b1)
        begin
            next_cycle();
        end
        check_val(test, expected_digest(n), mbox_resp);
    endtask

    // Refused write must not touch the SRAM
    task automatic refused_write(input string test);
        mbox_wr    = 1'b1;
        mbox_wdata = lcg_next();
        #10;
        check_val(test, 32'd0, word_t'(mbox_sram_cs));
        next_cycle();
        mbox_wr = 1'b0;
        expect_error_pulse(test);
    endtask

    task automatic reset_values();
        check_val("reset", 32'd1, word_t'(ready_for_fuses));
        check_val("reset", 32'd0, word_t'(ready_for_mb_processing));
        check_val("reset", 32'd0, word_t'(mbox_lock));
        check_val("reset", 32'd0, word_t'(mailbox_data_avail));
        check_val("reset", 32'd0, word_t'(cptra_error_non_fatal));
        check_val("reset", 32'd0, word_t'(mbox_sram_cs));
    endtask

    task automatic fuse_phase();
        mbox_lock_req = 1'b1;
        next_cycle();
        mbox_lock_req = 1'b0;
        check_val("fuse_lock", 32'd0, word_t'(mbox_lock));
        for (int i = 0; i < OBF_KEY_WORDS; i++)
        begin
            key_ref[i] = lcg_next();
            fuse_we    = 1'b1;
            fuse_addr  = fuse_addr_t'(i);
            fuse_wdata = key_ref[i];
            next_cycle();
        end
        fuse_we   = 1'b0;
        fuse_done = 1'b1;
        next_cycle();
        fuse_done = 1'b0;
        check_val("fuse_done", 32'd0, word_t'(ready_for_fuses));
        check_val("fuse_done", 32'd1, word_t'(ready_for_mb_processing));
        // Late key write must leave the loaded key in place
        fuse_we    = 1'b1;
        fuse_addr  = '0;
        fuse_wdata = ~key_ref[0];
        next_cycle();
        fuse_we = 1'b0;
        expect_error_pulse("fuse_late");
    endtask

    task automatic short_message();
        lock_mbox("short");
        fill_message("short", 8);
        execute_and_wait("short", 8);
        release_mbox("short");
    endtask

    task automatic full_message();
        lock_mbox("full");
        fill_message("full", MBOX_DEPTH);
        refused_write("full_overflow");
        execute_and_wait("full", MBOX_DEPTH);
        release_mbox("full");
        lock_mbox("empty");
        execute_and_wait("empty", 0);
        release_mbox("empty");
    endtask

    task automatic protocol_misuse();
        word_t resp;
        refused_write("wr_no_lock");
        check_val("wr_no_lock", 32'd0, word_t'(mbox_lock));
        mbox_execute = 1'b1;
        next_cycle();
        mbox_execute = 1'b0;
        expect_error_pulse("exec_no_lock");
        check_val("exec_no_lock", 32'd0, word_t'(mbox_lock));
        check_val("exec_no_lock", 32'd0, word_t'(mailbox_data_avail));
        lock_mbox("wr_avail");
        fill_message("wr_avail", 4);
        execute_and_wait("wr_avail", 4);
        resp = mbox_resp;
        refused_write("wr_avail");
        check_val("wr_avail", 32'd1, word_t'(mbox_lock));
        check_val("wr_avail", 32'd1, word_t'(mailbox_data_avail));
        check_val("wr_avail", resp, mbox_resp);
        release_mbox("misuse_release");
    endtask

    initial
    begin
        lcg_state     = 32'd11;
        rst           = 1'b1;
        fuse_we       = 1'b0;
        fuse_addr     = '0;
        fuse_wdata    = '0;
        fuse_done     = 1'b0;
        mbox_lock_req = 1'b0;
        mbox_wr       = 1'b0;
        mbox_wdata    = '0;
        mbox_execute  = 1'b0;
        mbox_release  = 1'b0;
        repeat (2) @(posedge core_clk);
        #2;
        rst = 1'b0;

        reset_values();
        fuse_phase();
        short_message();
        full_message();
        protocol_misuse();

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/boot_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module boot_fsm
    import rot_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // Fuse load port from the SoC
    input  logic       fuse_we,
    input  fuse_addr_t fuse_addr,
    input  word_t      fuse_wdata,
    input  logic       fuse_done,

    output logic       ready_for_fuses,
    output logic       mb_ready,
    output obf_key_t   obf_key,
    output logic       fuse_err
);

    boot_state_t state;
    obf_key_t    key_q;

    logic        in_fuse;

    assign in_fuse = (state == BOOT_FUSE);

    // Sequencer leaves the fuse phase once and stays in mailbox mode
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= BOOT_FUSE;
        end
        else if (in_fuse && fuse_done)
        begin
            state <= BOOT_MBOX;
        end
    end

    // Key words accepted only during the fuse phase
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            key_q <= '0;
        end
        else if (in_fuse && fuse_we)
        begin
            key_q[fuse_addr] <= fuse_wdata;
        end
    end

    assign ready_for_fuses = in_fuse;
    assign mb_ready        = (state == BOOT_MBOX);
    assign obf_key         = key_q;

    // Late fuse write, registered into the error pulse by the controller
    assign fuse_err = fuse_we && !in_fuse;

endmodule

`default_nettype wire

// File: verilog/mbox_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mbox_ctrl
    import rot_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       mb_ready,
    input  logic       fuse_err,

    // SoC mailbox port
    input  logic       mbox_lock_req,
    input  logic       mbox_wr,
    input  word_t      mbox_wdata,
    input  logic       mbox_execute,
    input  logic       mbox_release,

    output logic       mbox_lock,
    output logic       mailbox_data_avail,
    output word_t      mbox_resp,
    output logic       cptra_error_non_fatal,

    // Exported SRAM port
    output logic       mbox_sram_cs,
    output logic       mbox_sram_we,
    output mbox_addr_t mbox_sram_addr,
    output word_t      mbox_sram_wdata,
    input  word_t      mbox_sram_rdata,

    // Digest engine control
    output logic       dig_start,
    output mbox_cnt_t  dig_len,
    input  logic       dig_done,
    input  word_t      dig_result,

    mbox_rd_if.ctrl    rd
);

    mbox_state_t state;
    mbox_cnt_t   msg_cnt;
    logic        rd_pend;

    logic        wr_ok;
    logic        wr_err;
    logic        exec_ok;
    logic        exec_err;
    logic        rel_ok;

    // Writes only while locked and below the mailbox size
    assign wr_ok  = mbox_wr && (state == MB_LOCKED) &&
                    (msg_cnt != mbox_cnt_t'(MBOX_DEPTH));
    assign wr_err = mbox_wr && !wr_ok;

    assign exec_ok  = mbox_execute && (state == MB_LOCKED) && !mbox_release;
    assign exec_err = mbox_execute && (state == MB_IDLE);

    // No release while the engine still owns the SRAM
    assign rel_ok = mbox_release && ((state == MB_LOCKED) || (state == MB_DONE));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= MB_IDLE;
        end
        else
        begin
            case (state)
                MB_IDLE:
                begin
                    if (mbox_lock_req && mb_ready)
                        state <= MB_LOCKED;
                end
                MB_LOCKED:
                begin
                    if (rel_ok)
                        state <= MB_IDLE;
                    else if (exec_ok)
                        state <= MB_EXEC;
                end
                MB_EXEC:
                begin
                    if (dig_done)
                        state <= MB_DONE;
                end
                MB_DONE:
                begin
                    if (rel_ok)
                        state <= MB_IDLE;
                end
                default:
                begin
                    state <= MB_IDLE;
                end
            endcase
        end
    end

    // Message length, also the next write address
    always_ff @(posedge clk)
    begin
        if (rst)
            msg_cnt <= '0;
        else if (rel_ok)
            msg_cnt <= '0;
        else if (wr_ok)
            msg_cnt <= msg_cnt + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if ((state == MB_EXEC) && dig_done)
            mbox_resp <= dig_result;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_pend               <= 1'b0;
            cptra_error_non_fatal <= 1'b0;
        end
        else
        begin
            rd_pend               <= rd.req;
            cptra_error_non_fatal <= fuse_err || wr_err || exec_err;
        end
    end

    // SoC writes happen in MB_LOCKED, engine reads in MB_EXEC
    assign mbox_sram_cs    = wr_ok || rd.req;
    assign mbox_sram_we    = wr_ok;
    assign mbox_sram_addr  = wr_ok ? mbox_addr_t'(msg_cnt) : rd.addr;
    assign mbox_sram_wdata = mbox_wdata;

    // One-cycle SRAM read latency
    assign rd.rvalid = rd_pend;
    assign rd.rdata  = mbox_sram_rdata;

    assign dig_start = exec_ok;
    assign dig_len   = msg_cnt;

    assign mbox_lock          = (state != MB_IDLE);
    assign mailbox_data_avail = (state == MB_DONE);

endmodule

`default_nettype wire

// File: verilog/mbox_digest.sv
`timescale 1ns/1ps
`default_nettype none

module mbox_digest
    import rot_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      start,
    input  mbox_cnt_t len,
    input  obf_key_t  obf_key,

    mbox_rd_if.eng    rd,

    output logic      done,
    output word_t     result
);

    dig_state_t state;
    mbox_cnt_t  len_q;
    mbox_cnt_t  issue_cnt;
    mbox_cnt_t  fold_cnt;
    word_t      acc;

    logic       last_fold;

    // Reads run ahead of the fold, up to the SRAM latency
    assign rd.req  = (state == DG_READ) && (issue_cnt != len_q);
    assign rd.addr = mbox_addr_t'(issue_cnt);

    assign last_fold = rd.rvalid && ((fold_cnt + 1'b1) == len_q);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= DG_IDLE;
            issue_cnt <= '0;
            fold_cnt  <= '0;
        end
        else
        begin
            case (state)
                DG_IDLE:
                begin
                    if (start)
                    begin
                        issue_cnt <= '0;
                        fold_cnt  <= '0;
                        // Empty message is done at once with a zero digest
                        state     <= (len == '0) ? DG_DONE : DG_READ;
                    end
                end
                DG_READ:
                begin
                    if (rd.req)
                        issue_cnt <= issue_cnt + 1'b1;
                    if (rd.rvalid)
                        fold_cnt <= fold_cnt + 1'b1;
                    if (last_fold)
                        state <= DG_DONE;
                end
                DG_DONE:
                begin
                    state <= DG_IDLE;
                end
                default:
                begin
                    state <= DG_IDLE;
                end
            endcase
        end
    end

    // Rotate left by one, then mix in the word and its key word
    always_ff @(posedge clk)
    begin
        if ((state == DG_IDLE) && start)
        begin
            len_q <= len;
            acc   <= '0;
        end
        else if ((state == DG_READ) && rd.rvalid)
        begin
            acc <= {acc[WORD_W-2:0], acc[WORD_W-1]} ^ rd.rdata ^
                   obf_key[fuse_addr_t'(fold_cnt)];
        end
    end

    assign done   = (state == DG_DONE);
    assign result = acc;

endmodule

`default_nettype wire

// File: verilog/mbox_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

// Read path from the digest engine into the mailbox SRAM port
interface mbox_rd_if
    import rot_pkg::*;
();

    logic       req;
    mbox_addr_t addr;
    logic       rvalid;
    word_t      rdata;

    // Digest engine side
    modport eng (
        output req,
        output addr,
        input  rvalid,
        input  rdata
    );

    // Mailbox controller side
    modport ctrl (
        input  req,
        input  addr,
        output rvalid,
        output rdata
    );

endinterface

`default_nettype wire

// File: verilog/rot_pkg.sv
`default_nettype none

package rot_pkg;

    // Data path and mailbox sizes
    localparam int WORD_W        = 32;
    localparam int MBOX_DEPTH    = 64;
    localparam int MBOX_ADDR_W   = 6;
    localparam int MBOX_CNT_W    = 7;

    // Obfuscation key layout
    localparam int OBF_KEY_WORDS = 4;
    localparam int FUSE_ADDR_W   = 2;

    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [MBOX_ADDR_W-1:0] mbox_addr_t;
    // One bit wider than the address so a full mailbox can be counted
    typedef logic [MBOX_CNT_W-1:0]  mbox_cnt_t;
    typedef logic [FUSE_ADDR_W-1:0] fuse_addr_t;

    typedef word_t [OBF_KEY_WORDS-1:0] obf_key_t;

    typedef enum logic {
        BOOT_FUSE,
        BOOT_MBOX
    } boot_state_t;

    typedef enum logic [1:0] {
        MB_IDLE,
        MB_LOCKED,
        MB_EXEC,
        MB_DONE
    } mbox_state_t;

    typedef enum logic [1:0] {
        DG_IDLE,
        DG_READ,
        DG_DONE
    } dig_state_t;

endpackage

`default_nettype wire

// File: verilog/rot_top.sv
`timescale 1ns/1ps
`default_nettype none

module rot_top
    import rot_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // Fuse port
    input  logic       fuse_we,
    input  fuse_addr_t fuse_addr,
    input  word_t      fuse_wdata,
    input  logic       fuse_done,

    // Mailbox port
    input  logic       mbox_lock_req,
    input  logic       mbox_wr,
    input  word_t      mbox_wdata,
    input  logic       mbox_execute,
    input  logic       mbox_release,

    // Status
    output logic       ready_for_fuses,
    output logic       ready_for_mb_processing,
    output logic       mbox_lock,
    output logic       mailbox_data_avail,
    output word_t      mbox_resp,
    output logic       cptra_error_non_fatal,

    // Mailbox SRAM, served outside the subsystem
    output logic       mbox_sram_cs,
    output logic       mbox_sram_we,
    output mbox_addr_t mbox_sram_addr,
    output word_t      mbox_sram_wdata,
    input  word_t      mbox_sram_rdata
);

    logic      fuse_err;
    obf_key_t  obf_key;
    logic      dig_start;
    mbox_cnt_t dig_len;
    logic      dig_done;
    word_t     dig_result;

    mbox_rd_if rd_bus ();

    boot_fsm boot_fsm_i (
        .clk             (clk),
        .rst             (rst),
        .fuse_we         (fuse_we),
        .fuse_addr       (fuse_addr),
        .fuse_wdata      (fuse_wdata),
        .fuse_done       (fuse_done),
        .ready_for_fuses (ready_for_fuses),
        .mb_ready        (ready_for_mb_processing),
        .obf_key         (obf_key),
        .fuse_err        (fuse_err)
    );

    mbox_ctrl mbox_ctrl_i (
        .clk                   (clk),
        .rst                   (rst),
        .mb_ready              (ready_for_mb_processing),
        .fuse_err              (fuse_err),
        .mbox_lock_req         (mbox_lock_req),
        .mbox_wr               (mbox_wr),
        .mbox_wdata            (mbox_wdata),
        .mbox_execute          (mbox_execute),
        .mbox_release          (mbox_release),
        .mbox_lock             (mbox_lock),
        .mailbox_data_avail    (mailbox_data_avail),
        .mbox_resp             (mbox_resp),
        .cptra_error_non_fatal (cptra_error_non_fatal),
        .mbox_sram_cs          (mbox_sram_cs),
        .mbox_sram_we          (mbox_sram_we),
        .mbox_sram_addr        (mbox_sram_addr),
        .mbox_sram_wdata       (mbox_sram_wdata),
        .mbox_sram_rdata       (mbox_sram_rdata),
        .dig_start             (dig_start),
        .dig_len               (dig_len),
        .dig_done              (dig_done),
        .dig_result            (dig_result),
        .rd                    (rd_bus.ctrl)
    );

    mbox_digest mbox_digest_i (
        .clk     (clk),
        .rst     (rst),
        .start   (dig_start),
        .len     (dig_len),
        .obf_key (obf_key),
        .rd      (rd_bus.eng),
        .done    (dig_done),
        .result  (dig_result)
    );

endmodule

`default_nettype wire
